// File: verilog.f
rtl/wiscPkg.sv
rtl/controlDecoder.sv
rtl/instrFetch.sv
rtl/instrQueue.sv
rtl/decodeStage.sv
rtl/frontEnd.sv
testbench/frontEnd_sva.sv
testbench/frontEndTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the front end testbench with Verilator and runs it, a failing run exits non-zero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module frontEndTb -f verilog.f -o frontEndSim
./obj_dir/frontEndSim

// File: testbench/frontEndTb.sv
// Front end testbench: random instruction stream, reference decode model and handshake drivers
module frontEndTb;
    import wiscPkg::*;

    localparam int timeoutCycles = 200; // Longest wait on either link before giving up

    logic clk, arstN, instrReq, instrAck, ctrlAck, ctrlReq;
    logic [instrWidth-1:0]  instr;
    logic [pcWidth-1:0]     pc;
    logic [aluOpWidth-1:0]  aluOp;
    logic [1:0]             regSrc, bSrc, regDst;
    logic                   regWrt, slbi, branch, zeroExt, setFlag, sub, memEn, invA;
    logic                   invB, memWrt, immSrc, aluJmp, halt, btr, jmp;
    logic [regIdxWidth-1:0] readRegA, readRegB, writeReg;
    logic [instrWidth-1:0]  imm;

    integer      seed = 32'h3913a274;
    logic [31:0] expected[$];  // PC in the upper half, word in the lower, oldest first
    logic [15:0] pcNext = '0;  // PC the next sent word should carry
    logic [31:0] opSeen = '0;  // One bit per opcode that came out of decode
    int          maxAckWait;   // Longest instrAck wait, grows once the queue fills

    frontEnd #(.queueDepth(4)) frontEnd_i (.*);

    always #10 clk = !clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic compare(input string name, input logic [31:0] expValue,
                           input logic [31:0] actValue);
        if (expValue !== actValue) begin
            failRun($sformatf("Mismatch %s expected %h actual %h", name, expValue, actValue));
        end
    endtask

    // Packed as aluOp, regSrc, bSrc, regDst, then regWrt down to jmp in port order
    function automatic logic [24:0] expectedControl(input logic [4:0] op);
        logic [3:0] eAlu;
        logic [1:0] eRegSrc, eBSrc, eRegDst;
        logic       isImmAlu, isRType, isMem;
        logic       eRegWrt, eSlbi, eBranch, eZeroExt, eSetFlag, eSub, eMemEn, eInvA;
        logic       eInvB, eMemWrt, eImmSrc, eAluJmp, eHalt, eBtr, eJmp;
        isImmAlu = op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli};
        isRType  = op inside {opBtr, opArith, opShift, opSeq, opSlt, opSle, opSco};
        isMem    = op inside {opSt, opLd, opStu};
        eRegWrt  = isImmAlu || isRType || op inside {opLd, opStu, opLbi, opSlbi, opJal, opJalr};
        eSlbi    = op == opSlbi;
        eBranch  = op inside {opBeqz, opBnez, opBltz, opBgez};
        eZeroExt = op inside {opXori, opAndni, opSlbi}; // Logical immediates only
        eSetFlag = op inside {opSeq, opSlt, opSle, opSco};
        eSub     = op inside {opSubi, opSlt, opSle};
        eMemEn   = isMem;
        eInvA    = op == opSubi;
        eInvB    = op inside {opAndni, opSlt, opSle};
        eMemWrt  = op inside {opSt, opStu};
        eImmSrc  = op inside {opJ, opJal};
        eAluJmp  = op inside {opJr, opJalr};
        eHalt    = op == opHalt;
        eBtr     = op == opBtr;
        eJmp     = eImmSrc; // Both follow the PC relative jumps
        eRegSrc  = (op == opLd) ? 2'b01 : (op == opLbi) ? 2'b11 :
                   (isImmAlu || isRType || op inside {opStu, opSlbi}) ? 2'b10 : 2'b00;
        eBSrc    = (isImmAlu || isMem) ? 2'b01 : (op inside {opSlbi, opJr, opJalr}) ? 2'b10 : 2'b00;
        eRegDst  = (isImmAlu || op == opLd) ? 2'b01 : isRType ? 2'b10 :
                   (op inside {opJal, opJalr}) ? 2'b11 : 2'b00;
        case (op)
            opAddi, opSubi, opSt, opLd, opStu, opJr, opJalr, opSlt, opSle, opSco: eAlu = aluAdd;
            opXori, opSeq: eAlu = aluXor;
            opAndni:       eAlu = aluAndn;
            opSlli:        eAlu = aluSll;
            opRori:        eAlu = aluRor;
            opSrli:        eAlu = aluSrl;
            opShift:       eAlu = aluShift;
            opArith:       eAlu = aluArith;
            opSlbi:        eAlu = aluSlbi;
            default:       eAlu = aluRol; // ROLI, BTR and all ops without ALU work share code 0
        endcase
        return {eAlu, eRegSrc, eBSrc, eRegDst, eRegWrt, eSlbi, eBranch, eZeroExt, eSetFlag,
                eSub, eMemEn, eInvA, eInvB, eMemWrt, eImmSrc, eAluJmp, eHalt, eBtr, eJmp};
    endfunction

    function automatic int immWidthOf(input logic [4:0] op);
        if (op inside {opJ, opJal}) return 11;
        if (op inside {opLbi, opSlbi, opBeqz, opBnez, opBltz, opBgez, opJr, opJalr}) return 8;
        if (op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
                       opSt, opLd, opStu}) return 5;
        return 0; // No immediate field at all
    endfunction

    function automatic logic [15:0] extendImm(input logic [15:0] word, input int width,
                                              input logic zext);
        logic [15:0] mask;
        logic [15:0] value;
        if (width == 0) return '0;
        mask  = (16'h1 << width) - 16'h1;
        value = word & mask;
        if (!zext && word[width-1]) value = value | ~mask; // Copy the field's sign upward
        return value;
    endfunction

    function automatic logic [15:0] randomWord();
        logic [15:0] word;
        do begin
            word = 16'($random(seed));
        end while (word[15:11] == opHalt); // HALT only goes out in the last phase
        return word;
    endfunction

    task automatic checkWord();
        logic [31:0] entry;
        logic [15:0] word;
        logic [24:0] ctrl;
        logic [2:0]  regExp;
        if (expected.size() == 0) failRun("ctrlReq rose with no word outstanding");
        entry  = expected.pop_front();
        word   = entry[15:0];
        ctrl   = expectedControl(word[15:11]);
        regExp = (ctrl[16:15] == 2'b11) ? 3'd7 : word[10 - 3 * int'(ctrl[16:15]) -: 3]; // R7 or field
        opSeen[word[15:11]] = 1'b1;
        compare("pc", entry[31:16], pc);
        compare("aluOp", ctrl[24:21], aluOp);
        compare("regSrc", ctrl[20:19], regSrc);
        compare("bSrc", ctrl[18:17], bSrc);
        compare("regDst", ctrl[16:15], regDst);
        compare("regWrt..jmp", ctrl[14:0], {regWrt, slbi, branch, zeroExt, setFlag, sub, memEn,
                                            invA, invB, memWrt, immSrc, aluJmp, halt, btr, jmp});
        compare("readRegA", word[10:8], readRegA);
        compare("readRegB", word[7:5], readRegB);
        compare("writeReg", regExp, writeReg);
        compare("imm", extendImm(word, immWidthOf(word[15:11]), ctrl[11]), imm);
    endtask

    task automatic sendWord(input logic [15:0] word, input int gapMask);
        int waited;
        repeat ($random(seed) & gapMask) @(posedge clk); // Idle gap before the request
        @(posedge clk);
        instrReq <= 1'b1;
        instr    <= word;
        expected.push_back({pcNext, word});
        pcNext = pcNext + 16'd2;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) failRun("Timeout waiting for instrAck to rise");
        end while (!instrAck);
        if (waited > maxAckWait) maxAckWait = waited;
        @(posedge clk);
        instrReq <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) failRun("Timeout waiting for instrAck to fall");
        end while (instrAck);
    endtask

    task automatic takeWord(input int ackBase, input int ackMask);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) failRun("Timeout waiting for ctrlReq to rise");
        end while (!ctrlReq);
        checkWord();
        repeat (ackBase + ($random(seed) & ackMask)) @(posedge clk); // Slow consumer
        @(posedge clk);
        ctrlAck <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) failRun("Timeout waiting for ctrlReq to fall");
        end while (ctrlReq);
        @(posedge clk);
        ctrlAck <= 1'b0;
    endtask

    task automatic runPhase(input int count, input int gapMask, input int ackBase, input int ackMask);
        fork
            for (int i = 0; i < count; i++) begin
                sendWord(randomWord(), gapMask);
            end
            for (int j = 0; j < count; j++) begin
                takeWord(ackBase, ackMask);
            end
        join
    endtask

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        instrReq = 1'b0;
        instr    = '0;
        ctrlAck  = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        compare("instrAck", 0, instrAck);
        compare("ctrlReq", 0, ctrlReq);
        runPhase(500, 3, 0, 3);
        maxAckWait = 0;
        runPhase(40, 0, 16, 7); // Long ctrlAck delays back the queue up into fetch
        if (maxAckWait < 10) failRun("Queue never filled, instrAck was not held back");
        fork
            sendWord({opHalt, 11'($random(seed))}, 3);
            takeWord(0, 3);
        join
        @(posedge clk);
        instrReq <= 1'b1; // Fetch is halted now and must leave this unanswered
        instr    <= randomWord();
        repeat (50) begin
            @(negedge clk);
            if (instrAck) failRun("instrAck answered a request after HALT");
            if (ctrlReq) failRun("ctrlReq rose after HALT with nothing sent");
        end
        if (frontEnd_i.frontEndSva_i.failCount != 0) begin
            failRun("A handshake assertion failed during the run");
        end else if (opSeen !== 32'hffff_ffff) begin
            failRun("Not every opcode was delivered through decode");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: testbench/frontEnd_sva.sv
// Front end assertions: four-phase rules on both links and output stability during ctrlReq
module frontEndSva (
    input logic        clk,
    input logic        arstN,
    input logic        instrReq,
    input logic        instrAck,
    input logic        ctrlReq,
    input logic        ctrlAck,
    input logic [65:0] result // Every decoded output with pc on top
);
    int failCount = 0; // Checked by the testbench before it ends

    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        ctrlReq && !ctrlAck |=> ctrlReq)
        else begin
            failCount++;
            $error("ctrlReq dropped before ctrlAck was seen");
        end

    resultStable: assert property (@(posedge clk) disable iff (!arstN)
        ctrlReq |=> !ctrlReq || $stable(result))
        else begin
            failCount++;
            $error("Decoded outputs changed while ctrlReq was high");
        end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        !instrReq && !instrAck |=> !instrAck)
        else begin
            failCount++;
            $error("instrAck rose while instrReq was low");
        end

endmodule

bind frontEnd frontEndSva frontEndSva_i (
    .clk      (clk),
    .arstN    (arstN),
    .instrReq (instrReq),
    .instrAck (instrAck),
    .ctrlReq  (ctrlReq),
    .ctrlAck  (ctrlAck),
    .result   ({pc, aluOp, regSrc, bSrc, regDst, regWrt, slbi, branch, zeroExt, setFlag, sub,
                memEn, invA, invB, memWrt, immSrc, aluJmp, halt, btr, jmp, readRegA, readRegB,
                writeReg, imm})
);

// File: rtl/frontEnd.sv
// Processor front end: fetch receiver, instruction queue and decode stage
module frontEnd #(
    parameter int queueDepth = 4 // Queue entries, power of two
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            instrReq, // Inbound four-phase link
    input  logic [wiscPkg::instrWidth-1:0]  instr,
    output logic                            instrAck,
    input  logic                            ctrlAck,  // Outbound four-phase link
    output logic                            ctrlReq,
    output logic [wiscPkg::pcWidth-1:0]     pc,
    output logic [wiscPkg::aluOpWidth-1:0]  aluOp,
    output logic [1:0]                      regSrc, bSrc, regDst,
    output logic                            regWrt, slbi, branch, zeroExt, setFlag,
    output logic                            sub, memEn, invA, invB, memWrt,
    output logic                            immSrc, aluJmp, halt, btr, jmp,
    output logic [wiscPkg::regIdxWidth-1:0] readRegA, readRegB, writeReg,
    output logic [wiscPkg::instrWidth-1:0]  imm
);
    import wiscPkg::*;

    logic                          push, full; // Fetch to queue
    logic                          pop, empty; // Queue to decode
    logic [pcWidth+instrWidth-1:0] pushData;
    logic [pcWidth+instrWidth-1:0] popData;

    instrFetch instrFetch_i (
        .clk      (clk),
        .arstN    (arstN),
        .instrReq (instrReq),
        .instr    (instr),
        .full     (full),
        .instrAck (instrAck),
        .push     (push),
        .pushData (pushData)
    );

    instrQueue #(
        .queueDepth (queueDepth)
    ) instrQueue_i (
        .clk      (clk),
        .arstN    (arstN),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .popData  (popData),
        .full     (full),
        .empty    (empty)
    );

    // Every decode stage port has a same-named signal at this level
    decodeStage decodeStage_i (.*);

endmodule

// File: rtl/decodeStage.sv
// Decode stage: pops the queue, decodes the word and offers the result over a four-phase sender
module decodeStage (
    input  logic                                            clk,
    input  logic                                            arstN,
    input  logic [wiscPkg::pcWidth+wiscPkg::instrWidth-1:0] popData, // Head entry of the queue
    input  logic                                            empty,
    input  logic                                            ctrlAck,
    output logic                                            pop,
    output logic                                            ctrlReq,
    output logic [wiscPkg::pcWidth-1:0]                     pc,
    output logic [wiscPkg::aluOpWidth-1:0]                  aluOp,
    output logic [1:0]                                      regSrc, bSrc, regDst,
    output logic                                            regWrt, slbi, branch, zeroExt, setFlag,
    output logic                                            sub, memEn, invA, invB, memWrt,
    output logic                                            immSrc, aluJmp, halt, btr, jmp,
    output logic [wiscPkg::regIdxWidth-1:0]                 readRegA, readRegB, writeReg,
    output logic [wiscPkg::instrWidth-1:0]                  imm
);
    import wiscPkg::*;

    logic [instrWidth-1:0]  headInstr;
    logic [aluOpWidth-1:0]  aluOpNext;
    logic [1:0]             regSrcNext, bSrcNext, regDstNext;
    logic                   regWrtNext, slbiNext, branchNext, zeroExtNext, setFlagNext;
    logic                   subNext, memEnNext, invANext, invBNext, memWrtNext;
    logic                   immSrcNext, aluJmpNext, haltNext, btrNext, jmpNext;
    immFormat               immKind;
    logic [regIdxWidth-1:0] writeRegNext;
    logic [instrWidth-1:0]  immNext;
    logic                   ackWait; // ctrlReq is down, waiting for ctrlAck to follow

    assign headInstr = popData[instrWidth-1:0];

    controlDecoder controlDecoder_i (
        .opcode  (headInstr[instrWidth-1 -: opcodeWidth]),
        .aluOp   (aluOpNext),
        .regSrc  (regSrcNext),
        .bSrc    (bSrcNext),
        .regDst  (regDstNext),
        .immKind (immKind),
        .regWrt  (regWrtNext),
        .slbi    (slbiNext),
        .branch  (branchNext),
        .zeroExt (zeroExtNext),
        .setFlag (setFlagNext),
        .sub     (subNext),
        .memEn   (memEnNext),
        .invA    (invANext),
        .invB    (invBNext),
        .memWrt  (memWrtNext),
        .immSrc  (immSrcNext),
        .aluJmp  (aluJmpNext),
        .halt    (haltNext),
        .btr     (btrNext),
        .jmp     (jmpNext)
    );

    always_comb begin
        case (regDstNext)
            2'b00:   writeRegNext = headInstr[10:8]; // Rs, used by LBI, SLBI and STU
            2'b01:   writeRegNext = headInstr[7:5];
            2'b10:   writeRegNext = headInstr[4:2];
            default: writeRegNext = regIdxWidth'(7); // Link register
        endcase
    end

    // Fill bit is the field's top bit unless the opcode asks for zero extension
    always_comb begin
        case (immKind)
            immFive:   immNext = {{(instrWidth-5){!zeroExtNext && headInstr[4]}}, headInstr[4:0]};
            immEight:  immNext = {{(instrWidth-8){!zeroExtNext && headInstr[7]}}, headInstr[7:0]};
            immEleven: immNext = {{(instrWidth-11){!zeroExtNext && headInstr[10]}}, headInstr[10:0]};
            default:   immNext = '0;
        endcase
    end

    assign pop = !empty && !ctrlReq && !ackWait; // Only from idle, one word per handshake

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlReq <= 1'b0;
            ackWait <= 1'b0;
        end else if (pop) begin
            ctrlReq <= 1'b1; // Outputs are loaded on this same edge
        end else if (ctrlReq && ctrlAck) begin
            ctrlReq <= 1'b0;
            ackWait <= 1'b1;
        end else if (ackWait && !ctrlAck) begin
            ackWait <= 1'b0; // Handshake complete, next pop may follow
        end
    end

    // Result registers only load on a pop, so they hold while ctrlReq is high
    always_ff @(posedge clk) begin
        if (pop) begin
            pc       <= popData[instrWidth +: pcWidth];
            readRegA <= headInstr[10:8];
            readRegB <= headInstr[7:5];
            writeReg <= writeRegNext;
            imm      <= immNext;
            {aluOp, regSrc, bSrc, regDst} <= {aluOpNext, regSrcNext, bSrcNext, regDstNext};
            {regWrt, slbi, branch, zeroExt, setFlag} <=
                {regWrtNext, slbiNext, branchNext, zeroExtNext, setFlagNext};
            {sub, memEn, invA, invB, memWrt} <= {subNext, memEnNext, invANext, invBNext, memWrtNext};
            {immSrc, aluJmp, halt, btr, jmp} <= {immSrcNext, aluJmpNext, haltNext, btrNext, jmpNext};
        end
    end

endmodule

// File: rtl/instrQueue.sv
// Instruction queue: circular FIFO of PC and instruction pairs with full and empty flags
module instrQueue #(
    parameter int queueDepth = 4 // Number of entries, a power of two so the pointers wrap freely
) (
    input  logic                                            clk,
    input  logic                                            arstN,
    input  logic                                            push,
    input  logic [wiscPkg::pcWidth+wiscPkg::instrWidth-1:0] pushData,
    input  logic                                            pop,
    output logic [wiscPkg::pcWidth+wiscPkg::instrWidth-1:0] popData, // Head entry
    output logic                                            full,
    output logic                                            empty
);
    import wiscPkg::*;

    localparam int entryWidth = pcWidth + instrWidth;
    localparam int ptrWidth   = $clog2(queueDepth);

    logic [entryWidth-1:0] entries [queueDepth];
    logic [ptrWidth-1:0]   wrPtr; // Next free slot
    logic [ptrWidth-1:0]   rdPtr; // Oldest entry
    logic [ptrWidth:0]     count; // One extra bit so a full queue is told apart from an empty one

    assign popData = entries[rdPtr]; // Valid whenever the queue is not empty
    assign full    = count == (ptrWidth + 1)'(queueDepth);
    assign empty   = count == '0;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1; // Wraps at queueDepth
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end // Simultaneous push and pop leave the count alone
        end
    end

endmodule

// File: rtl/instrFetch.sv
// Instruction fetch: four-phase receiver that stamps each word with its PC and queues it
module instrFetch (
    input  logic                                            clk,
    input  logic                                            arstN,
    input  logic                                            instrReq, // Request from the source
    input  logic [wiscPkg::instrWidth-1:0]                  instr,    // Stable while instrReq is high
    input  logic                                            full,     // Queue has no free entry
    output logic                                            instrAck,
    output logic                                            push,
    output logic [wiscPkg::pcWidth+wiscPkg::instrWidth-1:0] pushData  // PC in the upper half
);
    import wiscPkg::*;

    logic [pcWidth-1:0] pc; // Address of the word now on the link
    logic               halted; // Set by HALT and held until reset
    logic               isHalt;

    assign isHalt = instr[instrWidth-1 -: opcodeWidth] == opHalt;

    // instrAck doubles as the state bit, low is idle and high is waiting for instrReq to drop
    assign push     = instrReq && !instrAck && !full && !halted; // Back-pressure holds off the ack
    assign pushData = {pc, instr};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrAck <= 1'b0;
            halted   <= 1'b0;
            pc       <= '0;
        end else if (push) begin
            instrAck <= 1'b1;   // Word is in the queue, acknowledge it
            halted   <= isHalt; // Only reachable while not yet halted
        end else if (instrAck && !instrReq) begin
            instrAck <= 1'b0;              // Fourth phase closes the handshake
            pc       <= pc + pcWidth'(2); // Next word sits two bytes on
        end
    end

endmodule

// File: rtl/controlDecoder.sv
// Control decoder: combinational table from opcode to datapath control signals
module controlDecoder (
    input  logic [wiscPkg::opcodeWidth-1:0] opcode,  // Instruction bits 15 to 11
    output logic [wiscPkg::aluOpWidth-1:0]  aluOp,
    output logic [1:0]                      regSrc,  // 01 memory, 10 ALU, 11 immediate
    output logic [1:0]                      bSrc,    // 00 register, 01 short imm, 10 long imm
    output logic [1:0]                      regDst,  // 00 Rs, 01 bits 7:5, 10 bits 4:2, 11 R7
    output wiscPkg::immFormat               immKind, // Width of the immediate field
    output logic                            regWrt, slbi, branch, zeroExt, setFlag,
    output logic                            sub, memEn, invA, invB, memWrt,
    output logic                            immSrc, aluJmp, halt, btr, jmp
);
    import wiscPkg::*;

    always_comb begin
        {aluOp, regSrc, bSrc, regDst} = '0; // Anything not named below decodes as a NOP
        {regWrt, slbi, branch, zeroExt, setFlag, sub, memEn, invA} = '0;
        {invB, memWrt, immSrc, aluJmp, halt, btr, jmp} = '0;
        immKind = immNone;

        case (opcode)
            opHalt: halt = 1'b1;
            opNop: immKind = immNone; // Nothing beyond the defaults

            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                regDst  = 2'b01; // Rd in bits 7:5
                regSrc  = 2'b10;
                regWrt  = 1'b1;
                bSrc    = 2'b01;
                immKind = immFive;
                case (opcode)
                    opAddi: aluOp = aluAdd;
                    opSubi: begin
                        aluOp = aluAdd; // Immediate minus Rs, so A is inverted
                        invA  = 1'b1;
                        sub   = 1'b1;
                    end
                    opXori: begin
                        aluOp   = aluXor;
                        zeroExt = 1'b1; // Logical immediates are zero extended
                    end
                    opAndni: begin
                        aluOp   = aluAndn;
                        invB    = 1'b1;
                        zeroExt = 1'b1;
                    end
                    opRoli: aluOp = aluRol;
                    opSlli: aluOp = aluSll;
                    opRori: aluOp = aluRor;
                    default: aluOp = aluSrl; // SRLI
                endcase
            end

            opSt, opLd, opStu: begin
                aluOp   = aluAdd; // Address is Rs plus the offset
                memEn   = 1'b1;
                bSrc    = 2'b01;
                immKind = immFive;
                memWrt  = opcode != opLd;
                if (opcode != opSt) begin
                    regWrt = 1'b1; // LD writes the loaded value, STU writes the new base
                    regDst = (opcode == opLd) ? 2'b01 : 2'b00;
                    regSrc = (opcode == opLd) ? 2'b01 : 2'b10;
                end
            end

            opLbi: begin
                regSrc  = 2'b11; // Immediate straight into Rs
                regWrt  = 1'b1;
                immKind = immEight;
            end
            opSlbi: begin
                aluOp   = aluSlbi; // Rs shifted up a byte, ORed with the immediate
                zeroExt = 1'b1;
                regWrt  = 1'b1;
                regSrc  = 2'b10;
                slbi    = 1'b1;
                bSrc    = 2'b10;
                immKind = immEight;
            end

            opBeqz, opBnez, opBltz, opBgez: begin
                branch  = 1'b1; // Condition kind is left in the opcode bits
                immKind = immEight;
            end

            opJr, opJalr: begin
                aluOp   = aluAdd; // Target is Rs plus the immediate
                bSrc    = 2'b10;
                aluJmp  = 1'b1;
                immKind = immEight;
                if (opcode == opJalr) begin
                    regWrt = 1'b1;
                    regDst = 2'b11; // Return address into R7
                end
            end
            opJ, opJal: begin
                immSrc  = 1'b1; // PC relative displacement
                jmp     = 1'b1;
                immKind = immEleven;
                if (opcode == opJal) begin
                    regWrt = 1'b1;
                    regDst = 2'b11;
                end
            end

            opBtr, opArith, opShift, opSeq, opSlt, opSle, opSco: begin
                regDst = 2'b10; // Rd in bits 4:2
                regWrt = 1'b1;
                regSrc = 2'b10;
                case (opcode)
                    opBtr: begin
                        aluOp = aluRol;
                        btr   = 1'b1;
                    end
                    opArith: aluOp = aluArith;
                    opShift: aluOp = aluShift;
                    opSeq: begin
                        aluOp   = aluXor; // Equal when the XOR is zero
                        setFlag = 1'b1;
                    end
                    opSlt, opSle: begin
                        aluOp   = aluAdd; // Compare by subtraction
                        sub     = 1'b1;
                        invB    = 1'b1;
                        setFlag = 1'b1;
                    end
                    default: begin
                        aluOp   = aluAdd; // SCO looks at the carry out
                        setFlag = 1'b1;
                    end
                endcase
            end

            default: immKind = immNone; // Unused opcodes behave like NOP
        endcase
    end

endmodule

// File: rtl/wiscPkg.sv
// WISC front end shared definitions: word widths, opcode map, ALU codes and immediate formats
package wiscPkg;

    localparam int instrWidth  = 16; // One instruction word
    localparam int pcWidth     = 16; // Byte address, so sequential words step by 2
    localparam int opcodeWidth = 5;  // Opcode sits in instruction bits 15 to 11
    localparam int regIdxWidth = 3;  // Eight architectural registers
    localparam int aluOpWidth  = 4;

    // Special and jump group
    localparam logic [opcodeWidth-1:0] opHalt  = 5'b00000; // Stops issue until reset
    localparam logic [opcodeWidth-1:0] opNop   = 5'b00001;
    localparam logic [opcodeWidth-1:0] opJ     = 5'b00100; // 11-bit displacement
    localparam logic [opcodeWidth-1:0] opJr    = 5'b00101;
    localparam logic [opcodeWidth-1:0] opJal   = 5'b00110; // Links into R7
    localparam logic [opcodeWidth-1:0] opJalr  = 5'b00111;
    localparam logic [opcodeWidth-1:0] opAddi  = 5'b01000; // Start of the 5-bit immediate ALU ops
    localparam logic [opcodeWidth-1:0] opSubi  = 5'b01001;
    localparam logic [opcodeWidth-1:0] opXori  = 5'b01010;
    localparam logic [opcodeWidth-1:0] opAndni = 5'b01011;
    localparam logic [opcodeWidth-1:0] opBeqz  = 5'b01100; // Branches carry an 8-bit offset
    localparam logic [opcodeWidth-1:0] opBnez  = 5'b01101;
    localparam logic [opcodeWidth-1:0] opBltz  = 5'b01110;
    localparam logic [opcodeWidth-1:0] opBgez  = 5'b01111;
    localparam logic [opcodeWidth-1:0] opSt    = 5'b10000;
    localparam logic [opcodeWidth-1:0] opLd    = 5'b10001;
    localparam logic [opcodeWidth-1:0] opSlbi  = 5'b10010;
    localparam logic [opcodeWidth-1:0] opStu   = 5'b10011; // Store with base register update
    localparam logic [opcodeWidth-1:0] opRoli  = 5'b10100;
    localparam logic [opcodeWidth-1:0] opSlli  = 5'b10101;
    localparam logic [opcodeWidth-1:0] opRori  = 5'b10110;
    localparam logic [opcodeWidth-1:0] opSrli  = 5'b10111;
    localparam logic [opcodeWidth-1:0] opLbi   = 5'b11000;
    localparam logic [opcodeWidth-1:0] opBtr   = 5'b11001; // Bit reversal of Rs
    localparam logic [opcodeWidth-1:0] opShift = 5'b11010; // R-type shifts, kind in the funct bits
    localparam logic [opcodeWidth-1:0] opArith = 5'b11011; // R-type add, sub, xor, andn
    localparam logic [opcodeWidth-1:0] opSeq   = 5'b11100;
    localparam logic [opcodeWidth-1:0] opSlt   = 5'b11101;
    localparam logic [opcodeWidth-1:0] opSle   = 5'b11110;
    localparam logic [opcodeWidth-1:0] opSco   = 5'b11111; // Set on carry out

    // ALU operation codes as the execute stage expects them
    localparam logic [aluOpWidth-1:0] aluRol   = 4'b0000;
    localparam logic [aluOpWidth-1:0] aluShift = 4'b0001; // Shift kind taken from the funct bits
    localparam logic [aluOpWidth-1:0] aluSll   = 4'b0010;
    localparam logic [aluOpWidth-1:0] aluRor   = 4'b0100;
    localparam logic [aluOpWidth-1:0] aluSrl   = 4'b0110;
    localparam logic [aluOpWidth-1:0] aluAdd   = 4'b1000;
    localparam logic [aluOpWidth-1:0] aluArith = 4'b1001; // Arithmetic kind taken from the funct bits
    localparam logic [aluOpWidth-1:0] aluSlbi  = 4'b1010;
    localparam logic [aluOpWidth-1:0] aluXor   = 4'b1100;
    localparam logic [aluOpWidth-1:0] aluAndn  = 4'b1110;

    // Width of the immediate field that an opcode carries
    typedef enum logic [1:0] {immNone, immFive, immEight, immEleven} immFormat;

endpackage
